// File: filelist.f
rapid_isa_pkg.sv
rapid_bus_pkg.sv
rapid_fetch.sv
rapid_decode.sv
rapid_regfile.sv
rapid_execute.sv
rapid_result.sv
rapid_cpu.sv
rapid_cpu_sva.sv
tb_clock_gen.sv
tb_rapid_cpu.sv

// File: Bender.yml
package:
  name: rapid

sources:
  # packages, then the core bottom up
  - rapid_isa_pkg.sv
  - rapid_bus_pkg.sv
  - rapid_fetch.sv
  - rapid_decode.sv
  - rapid_regfile.sv
  - rapid_execute.sv
  - rapid_result.sv
  - rapid_cpu.sv
  # testbench and bound assertions
  - target: test
    files:
      - rapid_cpu_sva.sv
      - tb_clock_gen.sv
      - tb_rapid_cpu.sv

// File: tb_rapid_cpu.sv
`timescale 1ns/1ns

// one random program runs on the DUT and on an instruction model here
// and each wishbone access of the DUT is held against the model's list
module tb_rapid_cpu
    import rapid_isa_pkg::*, rapid_bus_pkg::*;
();

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
    localparam int N_RAND      = 200;
    localparam int N_STORES    = 15;
    // random part, closing stores, then the self jump
    localparam int PROG_LEN    = N_RAND + N_STORES + 1;
    localparam int FINAL_IDX   = PROG_LEN - 1;
    localparam int CLK_NS      = 8;
    localparam int WATCHDOG_NS = (N_RAND + 16) * 8 * CLK_NS;

    logic            clk;
    logic            arst_n;
    logic [XLEN-1:0] imem_addr;
    logic [XLEN-1:0] imem_data;
    logic [XLEN-1:0] prog_idx;
    wb_m2s_s         wb_m2s;
    wb_s2m_s         wb_s2m;

    integer          seed;
    logic [XLEN-1:0] prog [PROG_LEN];
    // slave data memory indexed by adr modulo 256
    logic [XLEN-1:0] mem [256];
    // accesses the model expects with the oldest first
    wb_m2s_s         exp_acc [$];
    int              n_expected;
    int              n_served;
    logic            in_access;
    int              wait_left;

    tb_clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(10)) u_clock_gen (
        .o_clk   (clk),
        .o_arst_n(arst_n)
    );

    rapid_cpu #(.RESET_PC(RESET_PC)) dut (
        .i_clk      (clk),
        .i_arst_n   (arst_n),
        .o_imem_addr(imem_addr),
        .i_imem_data(imem_data),
        .o_wb       (wb_m2s),
        .i_wb       (wb_s2m)
    );

    // instruction port reads in the same cycle and returns nop past the program
    assign prog_idx  = imem_addr - RESET_PC;
    assign imem_data = (prog_idx < PROG_LEN) ? prog[prog_idx] : '0;

    function automatic logic [XLEN-1:0] fill_word(input int idx);
        // odd multiplier spreads every index bit over the word
        return (idx * 32'h9E37_79B9) ^ 32'h0F0F_5A5A;
    endfunction

    function automatic string fmt_access(input wb_m2s_s a);
        return $sformatf("we=%0b adr=%h dat=%h", a.we, a.adr, a.dat);
    endfunction

    //////////////////////////////
    // checks
    //////////////////////////////

    task automatic end_with_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_word(input string name, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h, expected %h", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic verify_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %b, expected %b", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    // store data only counts for stores
    task automatic match_access(input int idx, input wb_m2s_s got, input wb_m2s_s exp);
        if (got.we !== exp.we || got.adr !== exp.adr || (exp.we && got.dat !== exp.dat)) begin
            $display("MISMATCH at %0t ns: o_wb access %0d got %s, expected %s",
                     $time, idx, fmt_access(got), fmt_access(exp));
            end_with_failure();
        end
    endtask

    // the self jump refetches its two successors before each redirect
    // so fetch cycles over three words from the final jal on
    task automatic expect_loop_addr(input logic [XLEN-1:0] got);
        logic [XLEN-1:0] lo;
        lo = RESET_PC + FINAL_IDX;
        if (got < lo || got > lo + 2) begin
            $display("MISMATCH at %0t ns: o_imem_addr got %h, expected %h to %h",
                     $time, got, lo, lo + 2);
            end_with_failure();
        end
    endtask

    //////////////////////////////
    // program and model
    //////////////////////////////

    task automatic build_program();
        instr_s ins;
        int     off;
        for (int i = 0; i < N_RAND; i++) begin
            ins = instr_s'($random(seed));
            // forward only and never past the closing stores
            if (ins.opcode inside {OP_BEQ, OP_BNE, OP_JAL}) begin
                off = 1 + ($unsigned($random(seed)) % 4);
                if (i + off > N_RAND) begin
                    off = N_RAND - i;
                end
                ins.imm = 16'(off);
                // equal sources half the time so branches get taken
                if ($random(seed) & 1) begin
                    ins.rs2 = ins.rs1;
                end
            end
            prog[i] = ins;
        end
        // sw rk, k(r0) dumps every register
        for (int k = 1; k <= N_STORES; k++) begin
            prog[N_RAND + k - 1] = {OP_SW, 4'd0, 4'd0, 4'(k), 16'(k)};
        end
        prog[FINAL_IDX] = {OP_JAL, 12'd0, 16'd0};
    endtask

    task automatic run_model();
        logic [XLEN-1:0] regs [16];
        logic [XLEN-1:0] mmem [256];
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] wval;
        logic [XLEN-1:0] nxt;
        logic            wen;
        wb_m2s_s         acc;
        instr_s          ins;
        for (int i = 0; i < 16; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mmem[i] = fill_word(i);
        end
        pc = RESET_PC;
        while (pc != RESET_PC + FINAL_IDX) begin
            ins  = instr_s'(prog[pc - RESET_PC]);
            a    = regs[ins.rs1];
            b    = regs[ins.rs2];
            imm  = {{16{ins.imm[15]}}, ins.imm};
            nxt  = pc + 1;
            wen  = 1'b1;
            wval = '0;
            acc  = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: a + imm, dat: b};
            case (ins.opcode)
                OP_ADD:  wval = a + b;
                OP_SUB:  wval = a - b;
                OP_AND:  wval = a & b;
                OP_OR:   wval = a | b;
                OP_XOR:  wval = a ^ b;
                OP_SLT:  wval = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                OP_ADDI: wval = a + imm;
                OP_LUI:  wval = {ins.imm, 16'h0000};
                OP_LW: begin
                    wval = mmem[acc.adr[7:0]];
                    exp_acc.push_back(acc);
                end
                OP_SW: begin
                    wen    = 1'b0;
                    acc.we = 1'b1;
                    mmem[acc.adr[7:0]] = b;
                    exp_acc.push_back(acc);
                end
                OP_BEQ: begin
                    wen = 1'b0;
                    nxt = (a == b) ? pc + imm : nxt;
                end
                OP_BNE: begin
                    wen = 1'b0;
                    nxt = (a != b) ? pc + imm : nxt;
                end
                OP_JAL: begin
                    wval = pc + 1;
                    nxt  = pc + imm;
                end
                default: wen = 1'b0;
            endcase
            if (wen && ins.rd != 0) begin
                regs[ins.rd] = wval;
            end
            pc = nxt;
        end
    endtask

    //////////////////////////////
    // wishbone slave
    //////////////////////////////

    task automatic serve_access();
        wb_m2s_s exp;
        if (exp_acc.size() == 0) begin
            $display("unexpected data access at %0t ns to address %h after the last one",
                     $time, wb_m2s.adr);
            end_with_failure();
        end else begin
            exp = exp_acc.pop_front();
            match_access(n_served, wb_m2s, exp);
            if (wb_m2s.we) begin
                mem[wb_m2s.adr[7:0]] = wb_m2s.dat;
            end else begin
                wb_s2m.dat <= mem[wb_m2s.adr[7:0]];
            end
            wb_s2m.ack <= 1'b1;
            n_served++;
        end
    endtask

    // 0 to 3 wait states and an ack of one cycle
    always @(posedge clk) begin
        wb_s2m.ack <= 1'b0;
        if (!arst_n) begin
            in_access = 1'b0;
        end else if (wb_m2s.cyc && wb_m2s.stb && !wb_s2m.ack) begin
            if (!in_access) begin
                in_access = 1'b1;
                wait_left = $unsigned($random(seed)) % 4;
            end
            if (wait_left == 0) begin
                in_access = 1'b0;
                serve_access();
            end else begin
                wait_left--;
            end
        end
    end

    // a failed bound assertion ends the run one cycle later
    always @(posedge clk) begin
        if (dut.u_sva.fail_count != 0) begin
            $display("wishbone protocol assertion failed before %0t ns", $time);
            end_with_failure();
        end
    end

    //////////////////////////////
    // sequence and watchdog
    //////////////////////////////

    initial begin
        seed      = 4297;
        wb_s2m    = '0;
        in_access = 1'b0;
        wait_left = 0;
        n_served  = 0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
        end
        build_program();
        run_model();
        n_expected = exp_acc.size();
        // reset state during reset and one cycle after release
        @(posedge clk);
        do begin
            @(negedge clk);
            verify_flag("o_wb.cyc", wb_m2s.cyc, 1'b0);
            verify_flag("o_wb.stb", wb_m2s.stb, 1'b0);
            compare_word("o_imem_addr", imem_addr, RESET_PC);
        end while (!arst_n);
        wait (n_served == n_expected);
        // skip the ack cycle of the last store
        @(negedge clk);
        repeat (24) begin
            @(negedge clk);
            verify_flag("o_wb.cyc", wb_m2s.cyc, 1'b0);
            expect_loop_addr(imem_addr);
        end
        if (dut.u_sva.fail_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("%0d wishbone assertion failures during the run", dut.u_sva.fail_count);
            end_with_failure();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns with %0d of %0d data accesses done",
                 WATCHDOG_NS, n_served, n_expected);
        end_with_failure();
    end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ns

// free-running testbench clock and a power-on reset
// reset is held low for a number of rising edges, then released on an edge
module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic o_clk,
    output logic o_arst_n
);

    initial begin
        o_clk    = 1'b0;
        o_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        // release lines up with the other stimulus on the rising edge
        o_arst_n <= 1'b1;
    end

    always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

// File: rapid_cpu_sva.sv
`timescale 1ns/1ns

// wishbone classic checks on the data port of the core
// bound into every rapid_cpu instance
module rapid_cpu_sva import rapid_bus_pkg::*; (
    input logic    i_clk,
    input logic    i_arst_n,
    input wb_m2s_s i_wb_m2s,
    input wb_s2m_s i_wb_s2m
);

    // count of assertion failures so far
    int unsigned fail_count;

    initial fail_count = 0;

    //////////////////////////////
    // protocol rules
    //////////////////////////////

    // a strobe only inside a bus cycle
    a_stb_needs_cyc: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        i_wb_m2s.stb |-> i_wb_m2s.cyc
    ) else begin
        $error("stb high outside of a bus cycle");
        fail_count++;
    end

    // request fields frozen until the slave acks
    a_hold_until_ack: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        (i_wb_m2s.stb && !i_wb_s2m.ack) |=>
            ($stable(i_wb_m2s.adr) && $stable(i_wb_m2s.we) && $stable(i_wb_m2s.dat))
    ) else begin
        $error("adr, we or dat changed while waiting for ack");
        fail_count++;
    end

    // no bus cycle while the core is in reset
    a_idle_in_reset: assert property (
        @(posedge i_clk) !i_arst_n |-> !i_wb_m2s.cyc
    ) else begin
        $error("cyc high during reset");
        fail_count++;
    end

endmodule

bind rapid_cpu rapid_cpu_sva u_sva (
    .i_clk   (i_clk),
    .i_arst_n(i_arst_n),
    .i_wb_m2s(o_wb),
    .i_wb_s2m(i_wb)
);

// File: rapid_cpu.sv
`timescale 1ns/1ns

// rapid core top level
// fetch -> decode -> execute -> result, one advance signal for all
module rapid_cpu import rapid_isa_pkg::*, rapid_bus_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            i_clk,
    input  logic            i_arst_n,
    // asynchronous instruction port
    output logic [XLEN-1:0] o_imem_addr,
    input  logic [XLEN-1:0] i_imem_data,
    // wishbone classic data port
    output wb_m2s_s         o_wb,
    input  wb_s2m_s         i_wb
);

    // low only while a load or store waits for ack
    logic                 advance;
    // redirect from execute, also kills the word in decode
    logic                 pc_load;
    logic [XLEN-1:0]      pc_target;
    // register file read side
    logic [REG_IDX_W-1:0] rs1_idx;
    logic [REG_IDX_W-1:0] rs2_idx;
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      rs2_data;
    // stage bundles
    decode_s              dec;
    exec_s                exec;
    // retiring write, to the register file and to forwarding
    logic                 rf_we;
    logic [REG_IDX_W-1:0] rf_idx;
    logic [XLEN-1:0]      rf_data;

    rapid_fetch #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_advance  (advance),
        .i_pc_load  (pc_load),
        .i_pc_target(pc_target),
        .o_pc       (o_imem_addr)
    );

    // word for o_imem_addr arrives in the same cycle
    rapid_decode u_decode (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_advance(advance),
        .i_flush  (pc_load),
        .i_pc     (o_imem_addr),
        .i_instr  (i_imem_data),
        .o_rs1_idx(rs1_idx),
        .o_rs2_idx(rs2_idx),
        .o_dec    (dec)
    );

    rapid_regfile u_regfile (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_rs1_idx (rs1_idx),
        .i_rs2_idx (rs2_idx),
        .i_we      (rf_we),
        .i_rd_idx  (rf_idx),
        .i_rd_data (rf_data),
        .o_rs1_data(rs1_data),
        .o_rs2_data(rs2_data)
    );

    rapid_execute u_execute (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_advance  (advance),
        .i_dec      (dec),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .i_fwd_we   (rf_we),
        .i_fwd_idx  (rf_idx),
        .i_fwd_data (rf_data),
        .o_pc_load  (pc_load),
        .o_pc_target(pc_target),
        .o_exec     (exec)
    );

    rapid_result u_result (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_exec   (exec),
        .i_wb     (i_wb),
        .o_wb     (o_wb),
        .o_advance(advance),
        .o_rf_we  (rf_we),
        .o_rf_idx (rf_idx),
        .o_rf_data(rf_data)
    );

endmodule

// File: rapid_result.sv
`timescale 1ns/1ns

// result stage
// wishbone classic master for lw and sw, pipeline stall, write-back
module rapid_result import rapid_isa_pkg::*, rapid_bus_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_arst_n,
    input  exec_s                i_exec,
    input  wb_s2m_s              i_wb,
    output wb_m2s_s              o_wb,
    // high whenever every stage may move
    output logic                 o_advance,
    output logic                 o_rf_we,
    output logic [REG_IDX_W-1:0] o_rf_idx,
    output logic [XLEN-1:0]      o_rf_data
);

    // open: a waiting access may request
    // gap: the cycle after ack, cyc stays low
    typedef enum logic {
        BUS_OPEN,
        BUS_GAP
    } bus_state_e;

    bus_state_e state_q;
    logic       mem_op;
    logic       req;
    logic       ack;

    //////////////////////////////
    // wishbone master
    //////////////////////////////

    assign mem_op = i_exec.valid & (i_exec.is_load | i_exec.is_store);
    // request in the first cycle the access sits here
    assign req    = mem_op & (state_q == BUS_OPEN);
    // ack outside a request is ignored
    assign ack    = req & i_wb.ack;

    // adr, we and dat come from the exec register, which holds
    // while advance is low, so they are stable until ack
    always_comb begin
        o_wb.cyc = req;
        o_wb.stb = req;
        o_wb.we  = i_exec.is_store;
        o_wb.adr = i_exec.result;
        o_wb.dat = i_exec.store_data;
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= BUS_OPEN;
        end else if (ack) begin
            state_q <= BUS_GAP;
        end else begin
            state_q <= BUS_OPEN;
        end
    end

    // a back-to-back access also waits out the gap cycle
    assign o_advance = ~mem_op | ack;

    //////////////////////////////
    // write-back
    //////////////////////////////

    // also the forwarding source of execute
    // load data only counts in its ack cycle
    assign o_rf_we   = i_exec.valid & i_exec.rd_we & o_advance;
    assign o_rf_idx  = i_exec.rd;
    assign o_rf_data = i_exec.is_load ? i_wb.dat : i_exec.result;

endmodule

// File: rapid_execute.sv
`timescale 1ns/1ns

// execute stage
// operand register, forwarding from the retiring instruction, alu,
// branch resolution and the exec_s register feeding the result stage
module rapid_execute import rapid_isa_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_arst_n,
    input  logic                 i_advance,
    input  decode_s              i_dec,
    input  logic [XLEN-1:0]      i_rs1_data,
    input  logic [XLEN-1:0]      i_rs2_data,
    // retiring write from the result stage
    input  logic                 i_fwd_we,
    input  logic [REG_IDX_W-1:0] i_fwd_idx,
    input  logic [XLEN-1:0]      i_fwd_data,
    output logic                 o_pc_load,
    output logic [XLEN-1:0]      o_pc_target,
    output exec_s                o_exec
);

    decode_s         dec_q;
    logic [XLEN-1:0] rs1_q;
    logic [XLEN-1:0] rs2_q;
    logic            fwd_rs1;
    logic            fwd_rs2;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b_reg;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic            eq;
    exec_s           exec_d;

    //////////////////////////////
    // operand register
    //////////////////////////////

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            dec_q <= '0;
        end else if (i_advance) begin
            dec_q <= i_dec;
            // the instruction right behind a taken branch dies here
            dec_q.valid <= i_dec.valid & ~o_pc_load;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_advance) begin
            rs1_q <= i_rs1_data;
            rs2_q <= i_rs2_data;
        end
    end

    //////////////////////////////
    // forwarding and alu
    //////////////////////////////

    // producer one ahead is retiring now, its value is not in rs*_q yet
    // for a load this is only true in the ack cycle, which is also the
    // only cycle this stage advances
    assign fwd_rs1 = i_fwd_we && (dec_q.rs1 != '0) && (dec_q.rs1 == i_fwd_idx);
    assign fwd_rs2 = i_fwd_we && (dec_q.rs2 != '0) && (dec_q.rs2 == i_fwd_idx);

    assign op_a     = fwd_rs1 ? i_fwd_data : rs1_q;
    assign op_b_reg = fwd_rs2 ? i_fwd_data : rs2_q;
    assign op_b     = dec_q.use_imm ? dec_q.imm : op_b_reg;

    always_comb begin
        case (dec_q.alu_op)
            ALU_SUB:      alu_res = op_a - op_b;
            ALU_AND:      alu_res = op_a & op_b;
            ALU_OR:       alu_res = op_a | op_b;
            ALU_XOR:      alu_res = op_a ^ op_b;
            // signed compare, result is 0 or 1
            ALU_SLT:      alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_PASS_IMM: alu_res = op_b;
            default:      alu_res = op_a + op_b;
        endcase
    end

    //////////////////////////////
    // branch resolution
    //////////////////////////////

    assign eq = (op_a == op_b_reg);

    // held until advance, fetch and decode only act on it then
    assign o_pc_load = dec_q.valid &
                       (dec_q.is_jal | (dec_q.is_branch_eq & eq) | (dec_q.is_branch_ne & ~eq));
    // relative to the branch's own pc
    assign o_pc_target = dec_q.pc + dec_q.imm;

    //////////////////////////////
    // result register
    //////////////////////////////

    always_comb begin
        exec_d.valid = dec_q.valid;
        exec_d.rd    = dec_q.rd;
        exec_d.rd_we = dec_q.rd_we;
        // jal links to the next word
        exec_d.result     = dec_q.is_jal ? dec_q.pc + 1'b1 : alu_res;
        exec_d.store_data = op_b_reg;
        exec_d.is_load    = dec_q.is_load;
        exec_d.is_store   = dec_q.is_store;
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_exec <= '0;
        end else if (i_advance) begin
            o_exec <= exec_d;
        end
    end

endmodule

// File: rapid_regfile.sv
`timescale 1ns/1ns

// 16 x 32 register file, two read ports and one write port
module rapid_regfile import rapid_isa_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_arst_n,
    input  logic [REG_IDX_W-1:0] i_rs1_idx,
    input  logic [REG_IDX_W-1:0] i_rs2_idx,
    input  logic                 i_we,
    input  logic [REG_IDX_W-1:0] i_rd_idx,
    input  logic [XLEN-1:0]      i_rd_data,
    output logic [XLEN-1:0]      o_rs1_data,
    output logic [XLEN-1:0]      o_rs2_data
);

    logic [XLEN-1:0] regs [2**REG_IDX_W];

    // r0 is never written
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < 2**REG_IDX_W; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd_idx != '0)) begin
            regs[i_rd_idx] <= i_rd_data;
        end
    end

    // write-first, the retiring value is seen by decode in the same cycle
    // so an instruction two behind its producer needs no forwarding
    assign o_rs1_data = (i_rs1_idx == '0) ? '0 :
                        (i_we && (i_rd_idx == i_rs1_idx)) ? i_rd_data : regs[i_rs1_idx];
    assign o_rs2_data = (i_rs2_idx == '0) ? '0 :
                        (i_we && (i_rd_idx == i_rs2_idx)) ? i_rd_data : regs[i_rs2_idx];

endmodule

// File: rapid_decode.sv
`timescale 1ns/1ns

// decode stage
// holds the fetched word and its pc, drives the register file read
// indices and expands the word into decode_s
module rapid_decode import rapid_isa_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_arst_n,
    input  logic                 i_advance,
    // kill the word being fetched, a branch resolved this cycle
    input  logic                 i_flush,
    input  logic [XLEN-1:0]      i_pc,
    input  logic [XLEN-1:0]      i_instr,
    output logic [REG_IDX_W-1:0] o_rs1_idx,
    output logic [REG_IDX_W-1:0] o_rs2_idx,
    output decode_s              o_dec
);

    instr_s          instr_q;
    logic [XLEN-1:0] pc_q;
    logic            valid_q;
    logic [XLEN-1:0] imm_sext;
    logic [XLEN-1:0] imm_lui;

    // register-register opcodes to alu function
    function automatic alu_op_e alu_of(input opcode_e op);
        case (op)
            OP_SUB:  return ALU_SUB;
            OP_AND:  return ALU_AND;
            OP_OR:   return ALU_OR;
            OP_XOR:  return ALU_XOR;
            OP_SLT:  return ALU_SLT;
            default: return ALU_ADD;
        endcase
    endfunction

    //////////////////////////////
    // fetch word register
    //////////////////////////////

    // word resets to nop so nothing undefined reaches the decoder
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            instr_q <= '0;
            valid_q <= 1'b0;
        end else if (i_advance) begin
            instr_q <= instr_s'(i_instr);
            valid_q <= ~i_flush;
        end
    end

    // own pc of the word, base of branch targets and jal link
    always_ff @(posedge i_clk) begin
        if (i_advance) begin
            pc_q <= i_pc;
        end
    end

    // register file is read straight from the held word
    assign o_rs1_idx = instr_q.rs1;
    assign o_rs2_idx = instr_q.rs2;

    //////////////////////////////
    // decoder
    //////////////////////////////

    assign imm_sext = {{(XLEN-IMM_W){instr_q.imm[IMM_W-1]}}, instr_q.imm};
    // lui puts the field in the upper half
    assign imm_lui  = {instr_q.imm, {(XLEN-IMM_W){1'b0}}};

    always_comb begin
        // defaults give a nop: no write, no memory access, no redirect
        o_dec        = '0;
        o_dec.valid  = valid_q;
        o_dec.pc     = pc_q;
        o_dec.rd     = instr_q.rd;
        o_dec.rs1    = instr_q.rs1;
        o_dec.rs2    = instr_q.rs2;
        o_dec.alu_op = ALU_ADD;
        o_dec.imm    = imm_sext;
        case (instr_q.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT: begin
                o_dec.rd_we  = 1'b1;
                o_dec.alu_op = alu_of(instr_q.opcode);
            end
            OP_ADDI: begin
                o_dec.rd_we   = 1'b1;
                o_dec.use_imm = 1'b1;
            end
            OP_LUI: begin
                o_dec.rd_we   = 1'b1;
                o_dec.use_imm = 1'b1;
                o_dec.alu_op  = ALU_PASS_IMM;
                o_dec.imm     = imm_lui;
            end
            // address is rs1 plus immediate
            OP_LW: begin
                o_dec.rd_we   = 1'b1;
                o_dec.use_imm = 1'b1;
                o_dec.is_load = 1'b1;
            end
            // store data comes from rs2
            OP_SW: begin
                o_dec.use_imm  = 1'b1;
                o_dec.is_store = 1'b1;
            end
            OP_BEQ: o_dec.is_branch_eq = 1'b1;
            OP_BNE: o_dec.is_branch_ne = 1'b1;
            OP_JAL: begin
                o_dec.rd_we  = 1'b1;
                o_dec.is_jal = 1'b1;
            end
            // nop, 14 and 15
            default: ;
        endcase
    end

endmodule

// File: rapid_fetch.sv
`timescale 1ns/1ns

// program counter of the fetch stage
// o_pc goes straight out as the instruction address, the word
// comes back in the same cycle and is caught by the decode register
module rapid_fetch import rapid_isa_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            i_clk,
    input  logic            i_arst_n,
    // low while the result stage waits on the data bus
    input  logic            i_advance,
    // taken branch or jal from execute
    input  logic            i_pc_load,
    input  logic [XLEN-1:0] i_pc_target,
    output logic [XLEN-1:0] o_pc
);

    //////////////////////////////
    // pc register
    //////////////////////////////

    // word addressed, so sequential fetch is pc plus one
    // a redirect is only taken together with advance, otherwise the
    // branch sits in execute and is seen again next cycle
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pc <= RESET_PC;
        end else if (i_advance) begin
            if (i_pc_load) begin
                // target on the port in the cycle after resolve
                o_pc <= i_pc_target;
            end else begin
                o_pc <= o_pc + 1'b1;
            end
        end
        // stalled, address holds and the slave keeps returning the same word
    end

endmodule

// File: rapid_bus_pkg.sv
package rapid_bus_pkg;

    import rapid_isa_pkg::XLEN;

    // wishbone classic, master to slave
    // full words only, so no sel lines
    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic            we;
        logic [XLEN-1:0] adr;
        logic [XLEN-1:0] dat;
    } wb_m2s_s;

    // wishbone classic, slave to master
    typedef struct packed {
        logic            ack;
        logic [XLEN-1:0] dat;
    } wb_s2m_s;

endpackage

// File: rapid_isa_pkg.sv
package rapid_isa_pkg;

    // machine word, also the width of instruction and data addresses
    localparam int XLEN      = 32;
    // sixteen architectural registers
    localparam int REG_IDX_W = 4;
    // immediate field, sign-extended or shifted up by lui
    localparam int IMM_W     = 16;

    // opcodes 14 and 15 are unnamed and decode as nop
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_SLT  = 4'd6,
        OP_ADDI = 4'd7,
        OP_LUI  = 4'd8,
        OP_LW   = 4'd9,
        OP_SW   = 4'd10,
        OP_BEQ  = 4'd11,
        OP_BNE  = 4'd12,
        OP_JAL  = 4'd13
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_IMM
    } alu_op_e;

    // instruction word layout, msb first
    typedef struct packed {
        opcode_e              opcode;
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
        logic [IMM_W-1:0]     imm;
    } instr_s;

    // decode stage output, held in the execute register
    typedef struct packed {
        logic                 valid;
        logic [XLEN-1:0]      pc;
        logic [REG_IDX_W-1:0] rd;
        logic                 rd_we;
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
        alu_op_e              alu_op;
        // operand b comes from the immediate, not rs2
        logic                 use_imm;
        logic                 is_load;
        logic                 is_store;
        logic                 is_branch_eq;
        logic                 is_branch_ne;
        logic                 is_jal;
        logic [XLEN-1:0]      imm;
    } decode_s;

    // execute stage output, consumed by the result stage
    typedef struct packed {
        logic                 valid;
        logic [REG_IDX_W-1:0] rd;
        logic                 rd_we;
        // alu result, link value, or word address for loads and stores
        logic [XLEN-1:0]      result;
        logic [XLEN-1:0]      store_data;
        logic                 is_load;
        logic                 is_store;
    } exec_s;

endpackage
